// ==== logic/conv_loop_pkg.sv ====
package conv_loop_pkg;

	//////////////////////////////////////////////////
	// Dimensions

	localparam int IMAGE_WIDTH  = 4;
	localparam int IMAGE_SIZE   = IMAGE_WIDTH * IMAGE_WIDTH;
	localparam int CH_IN        = 4;
	localparam int CH_OUT       = 3;
	localparam int FMAP_DEPTH   = CH_IN * IMAGE_SIZE;
	localparam int WEIGHT_COUNT = CH_OUT * CH_IN;

	// Idle cycles between passes, one row plus one
	localparam int PASS_GAP  = IMAGE_WIDTH + 1;
	localparam int GAP_WIDTH = $clog2(PASS_GAP);

	//////////////////////////////////////////////////
	// Data and index types

	typedef logic signed [15:0] pixel_t;
	typedef logic signed [7:0]  weight_t;
	typedef logic signed [31:0] acc_t;

	typedef logic [$clog2(FMAP_DEPTH)-1:0] fmap_addr_t;
	typedef logic [$clog2(IMAGE_SIZE)-1:0] pix_idx_t;
	typedef logic [$clog2(CH_IN)-1:0]      ch_in_idx_t;
	typedef logic [1:0]                    ch_out_idx_t;

	// Sequencer states
	typedef enum logic [1:0] {
		LOAD,
		REPLAY,
		GAP,
		DONE
	} seq_state_t;

	// Rides along with every replayed buffer word
	typedef struct packed {
		ch_out_idx_t out_ch;
		ch_in_idx_t  in_ch;
		pix_idx_t    pix;
	} fmap_tag_t;

	typedef struct packed {
		ch_out_idx_t out_ch;
		pix_idx_t    pix;
		acc_t        value;
	} result_t;

endpackage

// ==== logic/fmap_buffer.sv ====
module fmap_buffer (
	input  logic                     clk,
	input  logic                     en,
	input  logic                     we,
	input  conv_loop_pkg::fmap_addr_t addr,
	input  conv_loop_pkg::pixel_t     wdata,
	output conv_loop_pkg::pixel_t     rdata
);

	import conv_loop_pkg::*;

	// One full input feature map, channel major
	pixel_t mem [FMAP_DEPTH];

	//////////////////////////////////////////////////
	// Single port, write first, registered read

	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[addr] <= wdata;
				// New data shows on the read port
				rdata     <= wdata;
			end else begin
				rdata <= mem[addr];
			end
		end
	end

endmodule

// ==== logic/loop_sequencer.sv ====
module loop_sequencer (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      in_valid,
	input  conv_loop_pkg::pixel_t     in_pixel,
	output logic                      busy,
	output logic                      mem_en,
	output logic                      mem_we,
	output conv_loop_pkg::fmap_addr_t mem_addr,
	output conv_loop_pkg::pixel_t     mem_wdata,
	output logic                      issue_valid,
	output conv_loop_pkg::fmap_tag_t  issue_tag
);

	import conv_loop_pkg::*;

	localparam fmap_addr_t LAST_ADDR = fmap_addr_t'(FMAP_DEPTH - 1);
	localparam ch_out_idx_t LAST_OUT_CH = ch_out_idx_t'(CH_OUT - 1);
	localparam logic [GAP_WIDTH-1:0] LAST_GAP = GAP_WIDTH'(PASS_GAP - 1);

	seq_state_t state;
	fmap_addr_t addr;
	ch_out_idx_t out_ch;
	logic [GAP_WIDTH-1:0] gap_cnt;

	// Input pixel held one cycle before the write
	logic wr_pending;
	pixel_t wdata_q;

	logic accept;
	logic last_addr;

	assign last_addr = (addr == LAST_ADDR);

	// High from the last write until the return to LOAD
	assign busy   = (state != LOAD) || (wr_pending && last_addr);
	assign accept = in_valid && !busy;

	//////////////////////////////////////////////////
	// Buffer and issue side

	assign mem_en      = wr_pending || (state == REPLAY);
	assign mem_we      = wr_pending;
	assign mem_addr    = addr;
	assign mem_wdata   = wdata_q;
	assign issue_valid = (state == REPLAY);

	// Plane and position straight from the address
	assign issue_tag.out_ch = out_ch;
	assign issue_tag.in_ch  = ch_in_idx_t'(addr / IMAGE_SIZE);
	assign issue_tag.pix    = pix_idx_t'(addr % IMAGE_SIZE);

	always_ff @(posedge clk) begin
		if (accept) begin
			wdata_q <= in_pixel;
		end
	end

	//////////////////////////////////////////////////
	// Load and replay FSM

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= LOAD;
			addr       <= '0;
			out_ch     <= '0;
			gap_cnt    <= '0;
			wr_pending <= 1'b0;
		end else begin
			wr_pending <= accept;
			case (state)
				LOAD: begin
					if (wr_pending) begin
						// Wraps to zero after the last word
						addr <= addr + 1'b1;
						if (last_addr) begin
							state  <= REPLAY;
							out_ch <= '0;
						end
					end
				end
				REPLAY: begin
					addr <= addr + 1'b1;
					if (last_addr) begin
						gap_cnt <= '0;
						if (out_ch == LAST_OUT_CH) begin
							state <= DONE;
						end else begin
							state <= GAP;
						end
					end
				end
				GAP: begin
					gap_cnt <= gap_cnt + 1'b1;
					if (gap_cnt == LAST_GAP) begin
						state  <= REPLAY;
						out_ch <= out_ch + 1'b1;
					end
				end
				DONE: begin
					state <= LOAD;
					addr  <= '0;
				end
				default: begin
					state <= LOAD;
				end
			endcase
		end
	end

endmodule

// ==== logic/weight_rom.sv ====
module weight_rom (
	input  logic                       clk,
	input  conv_loop_pkg::ch_out_idx_t out_ch,
	input  conv_loop_pkg::ch_in_idx_t  in_ch,
	output conv_loop_pkg::weight_t     weight
);

	import conv_loop_pkg::*;

	localparam int IDX_WIDTH = $clog2(WEIGHT_COUNT);

	// Output channel major, CH_IN entries per row
	weight_t table_q [WEIGHT_COUNT];

	logic [IDX_WIDTH-1:0] idx;

	initial begin
		$readmemh("weights.hex", table_q);
	end

	assign idx = IDX_WIDTH'(out_ch) * IDX_WIDTH'(CH_IN) + IDX_WIDTH'(in_ch);

	always_ff @(posedge clk) begin
		weight <= table_q[idx];
	end

endmodule

// ==== logic/pointwise_mac.sv ====
module pointwise_mac (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     word_valid,
	input  conv_loop_pkg::fmap_tag_t word_tag,
	input  conv_loop_pkg::pixel_t    pixel,
	input  conv_loop_pkg::weight_t   weight,
	output logic                     result_valid,
	output conv_loop_pkg::result_t   result
);

	import conv_loop_pkg::*;

	localparam ch_in_idx_t LAST_IN_CH = ch_in_idx_t'(CH_IN - 1);

	// One running sum per pixel position
	acc_t acc_mem [IMAGE_SIZE];

	acc_t product;
	acc_t sum;
	logic first_ch;
	logic last_ch;

	//////////////////////////////////////////////////
	// Multiply and accumulate

	// Both operands widened first, so the product is signed
	assign product  = acc_t'(pixel) * acc_t'(weight);
	assign first_ch = (word_tag.in_ch == '0);
	assign last_ch  = (word_tag.in_ch == LAST_IN_CH);

	// First channel of a pass starts a fresh sum
	assign sum = first_ch ? product : acc_mem[word_tag.pix] + product;

	always_ff @(posedge clk) begin
		if (word_valid) begin
			acc_mem[word_tag.pix] <= sum;
		end
	end

	//////////////////////////////////////////////////
	// Result register

	always_ff @(posedge clk) begin
		if (word_valid && last_ch) begin
			result.out_ch <= word_tag.out_ch;
			result.pix    <= word_tag.pix;
			result.value  <= sum;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			result_valid <= 1'b0;
		end else begin
			// Only the last input plane finishes a pixel
			result_valid <= word_valid && last_ch;
		end
	end

endmodule

// ==== logic/conv_loop_top.sv ====
module conv_loop_top (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   in_valid,
	input  conv_loop_pkg::pixel_t  in_pixel,
	output logic                   busy,
	output logic                   result_valid,
	output conv_loop_pkg::result_t result
);

	import conv_loop_pkg::*;

	logic       mem_en;
	logic       mem_we;
	fmap_addr_t mem_addr;
	pixel_t     mem_wdata;
	pixel_t     mem_rdata;

	logic      issue_valid;
	fmap_tag_t issue_tag;
	weight_t   weight;

	// Issue side delayed to meet buffer and ROM output
	logic      word_valid;
	fmap_tag_t word_tag;

	loop_sequencer loop_sequencer_inst (
		.clk        (clk),
		.reset      (reset),
		.in_valid   (in_valid),
		.in_pixel   (in_pixel),
		.busy       (busy),
		.mem_en     (mem_en),
		.mem_we     (mem_we),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.issue_valid(issue_valid),
		.issue_tag  (issue_tag)
	);

	fmap_buffer fmap_buffer_inst (
		.clk  (clk),
		.en   (mem_en),
		.we   (mem_we),
		.addr (mem_addr),
		.wdata(mem_wdata),
		.rdata(mem_rdata)
	);

	weight_rom weight_rom_inst (
		.clk   (clk),
		.out_ch(issue_tag.out_ch),
		.in_ch (issue_tag.in_ch),
		.weight(weight)
	);

	//////////////////////////////////////////////////
	// One stage alignment

	always_ff @(posedge clk) begin
		word_tag <= issue_tag;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			word_valid <= 1'b0;
		end else begin
			word_valid <= issue_valid;
		end
	end

	pointwise_mac pointwise_mac_inst (
		.clk         (clk),
		.reset       (reset),
		.word_valid  (word_valid),
		.word_tag    (word_tag),
		.pixel       (mem_rdata),
		.weight      (weight),
		.result_valid(result_valid),
		.result      (result)
	);

endmodule

// ==== bench/conv_loop_tb.sv ====
module conv_loop_tb;

	import conv_loop_pkg::*;

	localparam int JUNK_STROBES = 100;
	localparam int WAIT_LIMIT   = 1000;
	localparam int IDLE_CYCLES  = 20;

	// Idle result cycles between two output channels, the gap plus three skipped planes
	localparam int CHANNEL_IDLE = PASS_GAP + (CH_IN - 1) * IMAGE_SIZE;

	logic    clk;
	logic    reset;
	logic    in_valid;
	pixel_t  in_pixel;
	logic    busy;
	logic    result_valid;
	result_t result;

	weight_t weights [WEIGHT_COUNT];
	pixel_t  frame [FMAP_DEPTH];
	result_t expected_q [$];

	// Spacing between output channels
	int          cycle_count;
	int          last_cycle;
	ch_out_idx_t last_out_ch;
	logic        seen_result;

	conv_loop_top conv_loop_top_inst (
		.clk         (clk),
		.reset       (reset),
		.in_valid    (in_valid),
		.in_pixel    (in_pixel),
		.busy        (busy),
		.result_valid(result_valid),
		.result      (result)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Failure reporting and compares

	task automatic stop_with_errors();
		$display("Finished with errors");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic report_failure(input string what);
		$display("error at %0t: %s", $time, what);
		stop_with_errors();
	endtask

	task automatic compare_value(input acc_t got, input acc_t exp, input string what);
		if (got !== exp) begin
			$display("mismatch at %0t: %s value %0d, expected %0d", $time, what, got, exp);
			stop_with_errors();
		end
	endtask

	task automatic compare_out_ch(input ch_out_idx_t got, input ch_out_idx_t exp,
			input string what);
		if (got !== exp) begin
			$display("mismatch at %0t: %s out_ch %0d, expected %0d", $time, what, got, exp);
			stop_with_errors();
		end
	endtask

	task automatic compare_pix(input pix_idx_t got, input pix_idx_t exp, input string what);
		if (got !== exp) begin
			$display("mismatch at %0t: %s pix %0d, expected %0d", $time, what, got, exp);
			stop_with_errors();
		end
	endtask

	//////////////////////////////////////////////////
	// Reference model

	// 1x1 convolution over the stored frame
	function automatic acc_t expected_value(input int out_ch, input int pix);
		acc_t sum;
		sum = '0;
		for (int c = 0; c < CH_IN; c++) begin
			sum += acc_t'(weights[out_ch * CH_IN + c]) * acc_t'(frame[c * IMAGE_SIZE + pix]);
		end
		return sum;
	endfunction

	task automatic queue_expected();
		result_t exp;
		for (int o = 0; o < CH_OUT; o++) begin
			for (int p = 0; p < IMAGE_SIZE; p++) begin
				exp.out_ch = ch_out_idx_t'(o);
				exp.pix    = pix_idx_t'(p);
				exp.value  = expected_value(o, p);
				expected_q.push_back(exp);
			end
		end
	endtask

	task automatic fill_random_frame();
		for (int i = 0; i < FMAP_DEPTH; i++) begin
			frame[i] = pixel_t'($urandom);
		end
	endtask

	task automatic fill_constant_frame(input pixel_t value);
		for (int i = 0; i < FMAP_DEPTH; i++) begin
			frame[i] = value;
		end
	endtask

	//////////////////////////////////////////////////
	// Stimulus

	task automatic send_frame(input logic back_to_back);
		int gap;
		for (int i = 0; i < FMAP_DEPTH; i++) begin
			gap = back_to_back ? 0 : int'($urandom % 4);
			for (int g = 0; g < gap; g++) begin
				@(posedge clk);
				in_valid <= 1'b0;
			end
			@(posedge clk);
			in_valid <= 1'b1;
			in_pixel <= frame[i];
			@(negedge clk);
			if (busy) begin
				report_failure("busy was high while a frame pixel was sent");
			end
		end
		@(posedge clk);
		in_valid <= 1'b0;
	endtask

	// Strobes that the DUT must drop
	task automatic send_junk(input int count);
		for (int i = 0; i < count; i++) begin
			@(posedge clk);
			in_valid <= 1'b1;
			in_pixel <= pixel_t'($urandom);
			@(negedge clk);
			if (!busy) begin
				report_failure("busy was low while junk strobes were sent");
			end
		end
		@(posedge clk);
		in_valid <= 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Waits

	task automatic wait_for_results(input int limit);
		int waited;
		waited = 0;
		while (expected_q.size() != 0) begin
			if (waited == limit) begin
				report_failure("timeout waiting for all expected results");
			end
			@(negedge clk);
			waited++;
		end
	endtask

	task automatic wait_for_busy_low(input int limit);
		int waited;
		waited = 0;
		while (busy) begin
			if (waited == limit) begin
				report_failure("timeout waiting for busy to fall after the last result");
			end
			@(negedge clk);
			waited++;
		end
	endtask

	task automatic check_idle(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(negedge clk);
			if (busy || result_valid) begin
				report_failure("busy or result_valid high with no frame loaded");
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Checker

	initial begin
		result_t exp;
		string   label;
		int      idle;
		cycle_count = 0;
		last_cycle  = 0;
		last_out_ch = '0;
		seen_result = 1'b0;
		forever begin
			@(negedge clk);
			cycle_count++;
			if (result_valid) begin
				if (expected_q.size() == 0) begin
					report_failure("result_valid pulsed with no result expected");
				end else begin
					exp   = expected_q.pop_front();
					label = $sformatf("result for out_ch %0d pix %0d", exp.out_ch, exp.pix);
					compare_out_ch(result.out_ch, exp.out_ch, label);
					compare_pix(result.pix, exp.pix, label);
					compare_value(result.value, exp.value, label);
					// Next output channel of the same frame follows the pass gap
					idle = cycle_count - last_cycle - 1;
					if (seen_result && result.out_ch != last_out_ch && result.out_ch != '0
							&& idle != CHANNEL_IDLE) begin
						$display("mismatch at %0t: %s idle cycles %0d, expected %0d",
							$time, label, idle, CHANNEL_IDLE);
						stop_with_errors();
					end
					seen_result = 1'b1;
					last_cycle  = cycle_count;
					last_out_ch = result.out_ch;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Main sequence

	initial begin
		void'($urandom(48));
		$readmemh("weights.hex", weights);
		reset    = 1'b1;
		in_valid = 1'b0;
		in_pixel = '0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		check_idle(IDLE_CYCLES);

		// Random frame with gaps, junk during replay
		fill_random_frame();
		queue_expected();
		send_frame(1'b0);
		send_junk(JUNK_STROBES);
		wait_for_results(WAIT_LIMIT);
		wait_for_busy_low(4);

		// Next frame right after busy drops
		fill_random_frame();
		queue_expected();
		send_frame(1'b1);
		wait_for_results(WAIT_LIMIT);
		wait_for_busy_low(4);

		// Most negative pixel everywhere
		fill_constant_frame(16'sh8000);
		queue_expected();
		send_frame(1'b1);
		wait_for_results(WAIT_LIMIT);
		wait_for_busy_low(4);

		check_idle(IDLE_CYCLES);
		$display("Finished with no errors");
		$finish;
	end

endmodule

// ==== weights.hex ====
// One signed 8-bit weight per line in two's complement hex
// Line n holds the weight for out_ch = n / 4 and in_ch = n % 4
03
fd
7f
80
11
ef
05
01
c0
40
ff
22

// ==== verilog.f ====
logic/conv_loop_pkg.sv
logic/fmap_buffer.sv
logic/loop_sequencer.sv
logic/weight_rom.sv
logic/pointwise_mac.sv
logic/conv_loop_top.sv
bench/conv_loop_tb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing -j 0
TOP      := conv_loop_tb
FILELIST := verilog.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	-./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
